// File: rtl/div_counter.sv
`default_nettype none

`include "timer_defs.svh"

module div_counter
	import timer_pkg::*;
(
	input  logic       boga1mhz,
	input  logic       rst,
	input  reg_wr_t    wr,
	input  logic [1:0] tap_sel,
	output reg_byte_t  div_hi,
	output logic       tick
);

	div_count_t div_q;
	logic       tap_cur;
	logic       tap_q;

	// any write to DIV clears the whole divider, not just the upper byte
	always_ff @(posedge boga1mhz) begin
		if (rst) begin
			div_q <= '0;
		end else if (wr.div_wr) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1; // wraps freely
		end
	end

	always_comb begin
		unique case (tap_sel)
			2'd0: tap_cur = div_q[`TAP_SEL0];
			2'd1: tap_cur = div_q[`TAP_SEL1];
			2'd2: tap_cur = div_q[`TAP_SEL2];
			default: tap_cur = div_q[`TAP_SEL3];
		endcase
	end

	always_ff @(posedge boga1mhz) begin
		if (rst) begin
			tap_q <= 1'b0;
		end else begin
			tap_q <= tap_cur; // previous value of the selected tap
		end
	end

	// a clear that drops a high tap counts as an edge too
	assign tick   = tap_q & ~tap_cur;
	assign div_hi = div_q[`DIV_WIDTH-1 -: 8];

	a_tick_single: assert property (
		@(posedge boga1mhz) disable iff (rst)
		tick |=> !tick
	) else $error("div_counter: tick high for two cycles");

endmodule

`default_nettype wire

// File: rtl/tima_counter.sv
`default_nettype none

`include "timer_defs.svh"

module tima_counter
	import timer_pkg::*;
(
	input  logic      boga1mhz,
	input  logic      rst,
	input  reg_wr_t   wr,
	input  logic      tick,
	output reg_byte_t tima,
	output reg_byte_t tma,
	output tac_t      tac,
	output logic      int_timer
);

	reg_byte_t tima_q;
	reg_byte_t tima_next;
	reg_byte_t tma_q;
	tac_t      tac_q;
	logic      cnt_en;
	logic      ovf;
	logic      int_q;

	assign cnt_en = tick & tac_q[`TAC_EN_BIT];

	// a CPU write to TIMA beats a tick in the same cycle
	assign ovf = cnt_en && (tima_q == 8'hff) && !wr.tima_wr;

	always_comb begin
		tima_next = tima_q;
		if (wr.tima_wr) begin
			tima_next = wr.data;
		end else if (ovf) begin
			tima_next = tma_q; // reload from modulo
		end else if (cnt_en) begin
			tima_next = tima_q + 8'd1;
		end
	end

	always_ff @(posedge boga1mhz) begin
		if (rst) begin
			tima_q <= '0;
		end else begin
			tima_q <= tima_next;
		end
	end

	always_ff @(posedge boga1mhz) begin
		if (rst) begin
			tma_q <= '0;
		end else if (wr.tma_wr) begin
			tma_q <= wr.data;
		end
	end

	always_ff @(posedge boga1mhz) begin
		if (rst) begin
			tac_q <= '0;
		end else if (wr.tac_wr) begin
			tac_q <= wr.data[2:0]; // upper five bits not stored
		end
	end

	// interrupt follows the reload edge by one cycle
	always_ff @(posedge boga1mhz) begin
		if (rst) begin
			int_q <= 1'b0;
		end else begin
			int_q <= ovf;
		end
	end

	assign tima      = tima_q;
	assign tma       = tma_q;
	assign tac       = tac_q;
	assign int_timer = int_q;

	// single-cycle pulse right after TIMA sat at 0xff
	a_int_after_ovf: assert property (
		@(posedge boga1mhz) disable iff (rst)
		int_timer |-> ($past(tima == 8'hff) && !$past(int_timer))
	) else $error("tima_counter: int_timer without overflow or longer than one cycle");

endmodule

`default_nettype wire

// File: rtl/timer_bus.sv
`default_nettype none

`include "timer_defs.svh"

module timer_bus
	import timer_pkg::*;
(
	input  logic      boga1mhz,
	input  logic      rst,
	input  cpu_req_t  cpu_req,
	output cpu_rsp_t  cpu_rsp,
	output reg_wr_t   wr,
	input  reg_byte_t div_hi,
	input  reg_byte_t tima,
	input  reg_byte_t tma,
	input  tac_t      tac
);

	localparam reg_addr_t idx_div  = reg_addr_t'(`TIMER_ADDR_DIV);
	localparam reg_addr_t idx_tima = reg_addr_t'(`TIMER_ADDR_TIMA);
	localparam reg_addr_t idx_tma  = reg_addr_t'(`TIMER_ADDR_TMA);
	localparam reg_addr_t idx_tac  = reg_addr_t'(`TIMER_ADDR_TAC);

	port_state_t state_q;
	logic        take;
	logic        do_wr;
	logic [3:0]  strb_q; // div, tima, tma, tac
	reg_byte_t   wdata_q;
	reg_byte_t   rd_mux;
	reg_byte_t   rdata_q;

	// accept only from idle, so a held req after ack does nothing
	assign take  = (state_q == idle) && cpu_req.req;
	assign do_wr = take && cpu_req.we;

	always_ff @(posedge boga1mhz) begin
		if (rst) begin
			state_q <= idle;
		end else begin
			unique case (state_q)
				idle: if (cpu_req.req) state_q <= ack_hold;
				ack_hold: if (!cpu_req.req) state_q <= idle;
			endcase
		end
	end

	always_comb begin
		unique case (cpu_req.addr)
			idx_div:  rd_mux = div_hi;
			idx_tima: rd_mux = tima;
			idx_tma:  rd_mux = tma;
			default:  rd_mux = {5'b11111, tac}; // unused TAC bits read as one
		endcase
	end

	// strobes last exactly the first ack cycle
	always_ff @(posedge boga1mhz) begin
		if (rst) begin
			strb_q <= '0;
		end else begin
			strb_q[3] <= do_wr && (cpu_req.addr == idx_div);
			strb_q[2] <= do_wr && (cpu_req.addr == idx_tima);
			strb_q[1] <= do_wr && (cpu_req.addr == idx_tma);
			strb_q[0] <= do_wr && (cpu_req.addr == idx_tac);
		end
	end

	always_ff @(posedge boga1mhz) begin
		if (take) begin
			wdata_q <= cpu_req.wdata;
			rdata_q <= rd_mux; // value from the sampling cycle
		end
	end

	assign wr = '{div_wr: strb_q[3], tima_wr: strb_q[2], tma_wr: strb_q[1],
		tac_wr: strb_q[0], data: wdata_q};
	assign cpu_rsp = '{ack: (state_q == ack_hold), rdata: rdata_q};

	a_req_stable: assert property (
		@(posedge boga1mhz) disable iff (rst)
		(cpu_req.req && !cpu_rsp.ack) |=> ($stable(cpu_req.addr) && $stable(cpu_req.we))
	) else $error("timer_bus: addr or we changed before ack");

	a_no_req_in_ack: assert property (
		@(posedge boga1mhz) disable iff (rst)
		$rose(cpu_req.req) |-> !cpu_rsp.ack
	) else $error("timer_bus: req raised while ack still high");

endmodule

`default_nettype wire

// File: rtl/timer_defs.svh
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// low address bytes of the timer registers, 0xFF04 to 0xFF07
`define TIMER_ADDR_DIV  8'h04
`define TIMER_ADDR_TIMA 8'h05
`define TIMER_ADDR_TMA  8'h06
`define TIMER_ADDR_TAC  8'h07

// free-running divider, DIV shows the upper byte
`define DIV_WIDTH 16

// divider bit counted by TIMA for each TAC select value
`define TAP_SEL0 9 // period 1024
`define TAP_SEL1 3 // period 16
`define TAP_SEL2 5 // period 64
`define TAP_SEL3 7 // period 256

// TAC field positions
`define TAC_EN_BIT  2
`define TAC_SEL_MSB 1
`define TAC_SEL_LSB 0

`endif

// File: rtl/timer_pkg.sv
`default_nettype none

`include "timer_defs.svh"

package timer_pkg;

	typedef logic [7:0] reg_byte_t; // one register value
	typedef logic [1:0] reg_addr_t; // address minus 0xFF04
	typedef logic [`DIV_WIDTH-1:0] div_count_t;
	typedef logic [2:0] tac_t; // enable, select[1:0]

	// CPU side request, held stable while req is up
	typedef struct packed {
		logic      req;
		logic      we;
		reg_addr_t addr;
		reg_byte_t wdata;
	} cpu_req_t;

	// port response, rdata valid while ack is high
	typedef struct packed {
		logic      ack;
		reg_byte_t rdata;
	} cpu_rsp_t;

	// one-cycle write strobes into the divider and counter
	typedef struct packed {
		logic      div_wr;
		logic      tima_wr;
		logic      tma_wr;
		logic      tac_wr;
		reg_byte_t data;
	} reg_wr_t;

	typedef enum logic {
		idle,
		ack_hold
	} port_state_t;

endpackage

`default_nettype wire

// File: rtl/timer_top.sv
`default_nettype none

`include "timer_defs.svh"

module timer_top
	import timer_pkg::*;
(
	input  logic     boga1mhz,
	input  logic     rst,
	input  cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp,
	output logic     int_timer
);

	reg_wr_t   wr;
	reg_byte_t div_hi;
	reg_byte_t tima;
	reg_byte_t tma;
	tac_t      tac;
	logic      tick;

	timer_bus u_timer_bus (
		.boga1mhz (boga1mhz),
		.rst      (rst),
		.cpu_req  (cpu_req),
		.cpu_rsp  (cpu_rsp),
		.wr       (wr),
		.div_hi   (div_hi),
		.tima     (tima),
		.tma      (tma),
		.tac      (tac)
	);

	div_counter u_div_counter (
		.boga1mhz (boga1mhz),
		.rst      (rst),
		.wr       (wr),
		.tap_sel  (tac[`TAC_SEL_MSB:`TAC_SEL_LSB]), // TAC select picks the tap
		.div_hi   (div_hi),
		.tick     (tick)
	);

	tima_counter u_tima_counter (
		.boga1mhz  (boga1mhz),
		.rst       (rst),
		.wr        (wr),
		.tick      (tick),
		.tima      (tima),
		.tma       (tma),
		.tac       (tac),
		.int_timer (int_timer)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the timer testbench with Verilator; result goes to sim.log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module timer_tb -f sim.f -o timer_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/timer_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
echo "Simulation finished without failure"
exit 0

// File: sim.f
+incdir+rtl
rtl/timer_pkg.sv
rtl/div_counter.sv
rtl/tima_counter.sv
rtl/timer_bus.sv
rtl/timer_top.sv
tests/timer_tb.sv

// File: tests/timer_tb.sv
`default_nettype none

`include "timer_defs.svh"

module timer_tb
	import timer_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ack_timeout = 20; // cycles allowed per handshake wait

	localparam reg_addr_t addr_div  = reg_addr_t'(`TIMER_ADDR_DIV);
	localparam reg_addr_t addr_tima = reg_addr_t'(`TIMER_ADDR_TIMA);
	localparam reg_addr_t addr_tma  = reg_addr_t'(`TIMER_ADDR_TMA);
	localparam reg_addr_t addr_tac  = reg_addr_t'(`TIMER_ADDR_TAC);

	typedef enum {do_write, do_read, do_idle, do_mark, do_irq} op_kind_t;

	typedef struct {
		op_kind_t  op;
		reg_addr_t addr;
		reg_byte_t data;
		int        cycles; // idle length, req hold, or expected pulses
		reg_byte_t lo;
		reg_byte_t hi;
		string     what;
	} step_t;

	logic        clk;
	logic        rst;
	cpu_req_t    cpu_req;
	cpu_rsp_t    cpu_rsp;
	logic        int_timer;
	int          irq_count = 0;
	int          irq_base = 0;
	int unsigned lcg_state = 32'h3b5ad3e7;
	step_t       steps[$];

	timer_top u_timer_top (
		.boga1mhz  (clk),
		.rst       (rst),
		.cpu_req   (cpu_req),
		.cpu_rsp   (cpu_rsp),
		.int_timer (int_timer)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// one negedge lands inside every single-cycle pulse
	always @(negedge clk) begin
		if (int_timer === 1'b1) begin
			irq_count <= irq_count + 1;
		end
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		int unsigned span;
		span = hi - lo + 1;
		return lo + int'((lcg_next() >> 8) % span); // upper bits are better mixed
	endfunction

	function automatic reg_byte_t clamp_byte(input int v);
		if (v < 0) begin
			return 8'h00;
		end
		if (v > 255) begin
			return 8'hff;
		end
		return v[7:0];
	endfunction

	function automatic step_t wr_step(input reg_addr_t addr, input reg_byte_t data,
			input int hold);
		step_t s;
		s.op = do_write;
		s.addr = addr;
		s.data = data;
		s.cycles = hold;
		s.what = "write";
		return s;
	endfunction

	function automatic step_t rd_step(input string what, input reg_addr_t addr,
			input reg_byte_t lo, input reg_byte_t hi, input int hold);
		step_t s;
		s.op = do_read;
		s.addr = addr;
		s.data = 8'h00;
		s.cycles = hold;
		s.lo = lo;
		s.hi = hi;
		s.what = what;
		return s;
	endfunction

	function automatic step_t plain_step(input op_kind_t op, input int cycles);
		step_t s;
		s.op = op;
		s.cycles = cycles;
		s.what = "control";
		return s;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_byte(input string what, input reg_byte_t got, input reg_byte_t lo,
			input reg_byte_t hi);
		if ($isunknown(got) || got < lo || got > hi) begin
			abort_run($sformatf("error at %0t: %s read 0x%02h, expected 0x%02h to 0x%02h",
				$time, what, got, lo, hi));
		end
	endtask

	task automatic check_irq_count(input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("error at %0t: counted %0d timer interrupts, expected %0d",
				$time, got, exp));
		end
	endtask

	// one four-phase transfer between two falling edges
	task automatic bus_xfer(input logic we, input reg_addr_t addr, input reg_byte_t wdata,
			input int hold, output reg_byte_t rdata);
		int n;
		if (cpu_rsp.ack) begin
			abort_run("handshake broken: ack was already high when req was raised");
		end
		cpu_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata};
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!cpu_rsp.ack && n < ack_timeout);
		if (!cpu_rsp.ack) begin
			abort_run($sformatf("timeout: no ack within %0d cycles of req to register %0d",
				ack_timeout, addr));
		end
		if (n != 1) begin
			abort_run($sformatf("handshake broken: ack rose %0d cycles after req", n));
		end
		rdata = cpu_rsp.rdata;
		repeat (hold) begin
			@(negedge clk);
			if (!cpu_rsp.ack || cpu_rsp.rdata != rdata) begin
				abort_run("back-pressure broken: ack or rdata changed while req was held");
			end
		end
		cpu_req.req = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (cpu_rsp.ack && n < ack_timeout);
		if (cpu_rsp.ack) begin
			abort_run($sformatf("timeout: ack still high %0d cycles after req fell",
				ack_timeout));
		end
	endtask

	task automatic build_table();
		int        n;
		reg_byte_t m;
		reg_byte_t v;
		steps.push_back(rd_step("TIMA after reset", addr_tima, 8'h00, 8'h00, 0));
		steps.push_back(rd_step("TMA after reset", addr_tma, 8'h00, 8'h00, 0));
		steps.push_back(rd_step("DIV after reset", addr_div, 8'h00, 8'h00, 0));
		steps.push_back(rd_step("TAC after reset", addr_tac, 8'hf8, 8'hf8, 0));
		steps.push_back(wr_step(addr_tac, 8'h05, 0));
		steps.push_back(rd_step("TAC after write", addr_tac, 8'hfd, 8'hfd, 0));
		n = rand_range(300, 3000); // divider rate
		steps.push_back(wr_step(addr_div, 8'h5a, 0));
		steps.push_back(plain_step(do_idle, n));
		steps.push_back(rd_step("DIV after idle", addr_div, clamp_byte(n / 256 - 1),
			clamp_byte(n / 256 + 1), 0));
		steps.push_back(wr_step(addr_div, 8'h00, 0));
		steps.push_back(rd_step("DIV after clear", addr_div, 8'h00, 8'h01, 0));
		n = rand_range(64, 3000); // count at period 16
		steps.push_back(wr_step(addr_tima, 8'h00, 0));
		steps.push_back(plain_step(do_idle, n));
		steps.push_back(rd_step("TIMA counting", addr_tima, clamp_byte(n / 16 - 2),
			clamp_byte(n / 16 + 2), 0));
		v = clamp_byte(rand_range(0, 127)); // enable clear holds TIMA
		steps.push_back(wr_step(addr_tac, 8'h01, 0));
		steps.push_back(wr_step(addr_tima, v, 0));
		steps.push_back(plain_step(do_idle, rand_range(100, 1000)));
		steps.push_back(rd_step("TIMA disabled", addr_tima, v, v, 0));
		m = clamp_byte(rand_range(0, 240)); // reload value low enough to avoid a second wrap
		steps.push_back(wr_step(addr_tma, m, 0));
		steps.push_back(rd_step("TMA readback", addr_tma, m, m, 0));
		steps.push_back(wr_step(addr_tac, 8'h05, 0));
		steps.push_back(plain_step(do_mark, 0));
		steps.push_back(wr_step(addr_tima, 8'hfe, 0));
		steps.push_back(plain_step(do_idle, 64));
		steps.push_back(rd_step("TIMA after reload", addr_tima, m, m + 8'd3, 0));
		steps.push_back(plain_step(do_irq, 1));
		steps.push_back(wr_step(addr_tac, 8'h02, 4)); // held req after ack
		steps.push_back(rd_step("TAC held read", addr_tac, 8'hfa, 8'hfa, 3));
		m = clamp_byte(rand_range(0, 255));
		v = clamp_byte(rand_range(0, 255));
		steps.push_back(wr_step(addr_tma, m, 0));
		steps.push_back(wr_step(addr_tima, v, 0));
		steps.push_back(rd_step("TMA back-to-back", addr_tma, m, m, 0));
		steps.push_back(rd_step("TIMA back-to-back", addr_tima, v, v, 0));
	endtask

	initial begin
		reg_byte_t got;
		rst = 1'b1;
		cpu_req = '0;
		build_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (steps[i]) begin
			case (steps[i].op)
				do_write: bus_xfer(1'b1, steps[i].addr, steps[i].data, steps[i].cycles, got);
				do_read: begin
					bus_xfer(1'b0, steps[i].addr, 8'h00, steps[i].cycles, got);
					check_byte(steps[i].what, got, steps[i].lo, steps[i].hi);
				end
				do_idle: repeat (steps[i].cycles) @(negedge clk);
				do_mark: irq_base = irq_count;
				default: check_irq_count(irq_count - irq_base, steps[i].cycles);
			endcase
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
